// ==== vlog.f ====
+incdir+hw
hw/cache_addr_pkg.sv
hw/mshr_pkg.sv
hw/mshr_alloc.sv
hw/mshr_entry.sv
hw/mshr_rr_arb.sv
hw/mshr_ds_issue.sv
hw/mshr_top.sv
tests/tb_mshr.sv

// ==== tests/tb_mshr.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module tb_mshr;

    localparam int N = `MSHR_ENTRY_NUM;
    localparam int NUM_MISSES = 100;
    // each miss needs well under 30 cycles even with the stalls below
    localparam int CYCLE_LIMIT = 30 * NUM_MISSES;
    localparam int LF_STALL_END = 60;
    localparam int DS_STALL_BEGIN = 80;
    localparam int DS_STALL_END = 120;

    logic clk;
    logic rst;
    logic alloc_vld;
    mshr_pkg::entry_idx_t alloc_idx;
    logic alloc_rdy;
    logic update_en;
    mshr_pkg::entry_idx_t update_idx;
    cache_addr_pkg::tag_t update_tag;
    cache_addr_pkg::set_t update_set;
    cache_addr_pkg::way_t update_way;
    mshr_pkg::txnid_t update_txnid;
    logic ds_req_vld;
    mshr_pkg::entry_idx_t ds_req_idx;
    cache_addr_pkg::tag_t ds_req_tag;
    cache_addr_pkg::set_t ds_req_set;
    mshr_pkg::txnid_t ds_req_txnid;
    mshr_pkg::lfdb_id_t ds_req_lfdb_id;
    logic ds_req_rdy;
    logic lfdb_alloc_vld;
    mshr_pkg::lfdb_id_t lfdb_alloc_id;
    logic lfdb_alloc_rdy;
    logic ds_done;
    mshr_pkg::entry_idx_t ds_done_idx;
    mshr_pkg::lfdb_id_t ds_done_lfdb_id;
    logic lf_wr_vld;
    mshr_pkg::entry_idx_t lf_wr_idx;
    cache_addr_pkg::set_t lf_wr_set;
    cache_addr_pkg::way_t lf_wr_way;
    mshr_pkg::lfdb_id_t lf_wr_lfdb_id;
    logic lf_wr_rdy;
    logic fill_done;
    mshr_pkg::entry_idx_t fill_done_idx;

    // ====================
    // reference model
    // ====================

    mshr_pkg::entry_state_t st [N];
    cache_addr_pkg::tag_t m_tag [N];
    cache_addr_pkg::set_t m_set [N];
    cache_addr_pkg::way_t m_way [N];
    mshr_pkg::txnid_t m_txnid [N];
    mshr_pkg::lfdb_id_t m_lfdb [N];
    // who got a grant while this entry was waiting
    logic [N-1:0] ds_won [N];
    logic [N-1:0] lf_won [N];

    int resv_q[$];
    int slot_q[$];
    int data_idx_q[$];
    int data_lfdb_q[$];
    int fill_q[$];

    logic [31:0] lcg_state = 32'he2306e6f;
    int cycle = 0;
    int grants = 0;
    int done_misses = 0;
    int pulses = 0;
    int reqs = 0;
    int mismatches = 0;
    int other_errs = 0;
    logic full_seen = 1'b0;
    logic prev_ds_vld = 1'b0;
    logic prev_ds_rdy = 1'b0;
    logic [63:0] prev_ds_pld = '0;
    logic prev_lf_vld = 1'b0;
    logic prev_lf_rdy = 1'b0;
    logic [63:0] prev_lf_pld = '0;

    mshr_top DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // true about pct percent of the time, from the upper lcg bits
    function automatic logic roll(input int pct);
        logic [31:0] r;
        r = next_rand();
        return (r[31:16] % 100) < pct;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            other_errs++;
            $display("ERROR time=%0t %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ====================
    // observe one cycle
    // ====================

    task automatic observe();
        int low;
        int j;
        logic [63:0] ds_pld;
        logic [63:0] lf_pld;

        ds_pld = {ds_req_idx, ds_req_tag, ds_req_set, ds_req_txnid, ds_req_lfdb_id};
        lf_pld = {lf_wr_idx, lf_wr_set, lf_wr_way, lf_wr_lfdb_id};
        if (prev_ds_vld && !prev_ds_rdy) begin
            check_eq("ds_req_vld", 1, ds_req_vld);
            check_eq("ds_req_payload", prev_ds_pld, ds_pld);
        end
        if (prev_lf_vld && !prev_lf_rdy) begin
            check_eq("lf_wr_vld", 1, lf_wr_vld);
            check_eq("lf_wr_payload", prev_lf_pld, lf_pld);
        end

        low = -1;
        for (int i = 0; i < N; i++) begin
            if (low < 0 && st[i] == mshr_pkg::IDLE) begin
                low = i;
            end
        end
        check_eq("alloc_vld", low >= 0, alloc_vld);
        if (low >= 0) begin
            check_eq("alloc_idx", low, alloc_idx);
        end else begin
            full_seen = 1'b1;
        end

        if (ds_req_vld && ds_req_rdy) begin
            j = ds_req_idx;
            reqs++;
            check_true(st[j] == mshr_pkg::DS_REQ,
                       $sformatf("entry %0d sent a request in state %s", j, st[j].name()));
            check_eq("ds_req_tag", m_tag[j], ds_req_tag);
            check_eq("ds_req_set", m_set[j], ds_req_set);
            check_eq("ds_req_txnid", m_txnid[j], ds_req_txnid);
            if (slot_q.size() == 0) begin
                check_true(1'b0, "request left without a buffer slot taken");
            end else begin
                check_eq("ds_req_lfdb_id", slot_q.pop_front(), ds_req_lfdb_id);
            end
            for (int i = 0; i < N; i++) begin
                if (i != j && st[i] == mshr_pkg::DS_REQ) begin
                    check_true(!ds_won[i][j],
                               $sformatf("entry %0d granted twice while %0d waited", j, i));
                    ds_won[i][j] = 1'b1;
                end
            end
            st[j] = mshr_pkg::WAIT_DATA;
            data_idx_q.push_back(j);
            data_lfdb_q.push_back(ds_req_lfdb_id);
        end

        check_true(!(lfdb_alloc_rdy && !lfdb_alloc_vld), "buffer slot taken while none offered");
        if (lfdb_alloc_rdy) begin
            pulses++;
            slot_q.push_back(lfdb_alloc_id);
        end

        if (lf_wr_vld && lf_wr_rdy) begin
            j = lf_wr_idx;
            check_true(st[j] == mshr_pkg::LF_WRITE,
                       $sformatf("entry %0d wrote a linefill in state %s", j, st[j].name()));
            check_eq("lf_wr_set", m_set[j], lf_wr_set);
            check_eq("lf_wr_way", m_way[j], lf_wr_way);
            check_eq("lf_wr_lfdb_id", m_lfdb[j], lf_wr_lfdb_id);
            for (int i = 0; i < N; i++) begin
                if (i != j && st[i] == mshr_pkg::LF_WRITE) begin
                    check_true(!lf_won[i][j],
                               $sformatf("entry %0d wrote twice while %0d waited", j, i));
                    lf_won[i][j] = 1'b1;
                end
            end
            st[j] = mshr_pkg::WAIT_FILL;
            fill_q.push_back(j);
        end

        // strobes and grants that move entries at this edge
        if (alloc_vld && alloc_rdy) begin
            st[alloc_idx] = mshr_pkg::RESERVED;
            resv_q.push_back(alloc_idx);
            grants++;
        end
        if (update_en) begin
            j = update_idx;
            m_tag[j] = update_tag;
            m_set[j] = update_set;
            m_way[j] = update_way;
            m_txnid[j] = update_txnid;
            ds_won[j] = '0;
            st[j] = mshr_pkg::DS_REQ;
        end
        if (ds_done) begin
            j = ds_done_idx;
            m_lfdb[j] = ds_done_lfdb_id;
            lf_won[j] = '0;
            st[j] = mshr_pkg::LF_WRITE;
        end
        if (fill_done) begin
            st[fill_done_idx] = mshr_pkg::IDLE;
            done_misses++;
        end

        prev_ds_vld = ds_req_vld;
        prev_ds_rdy = ds_req_rdy;
        prev_ds_pld = ds_pld;
        prev_lf_vld = lf_wr_vld;
        prev_lf_rdy = lf_wr_rdy;
        prev_lf_pld = lf_pld;
    endtask

    // ====================
    // drive next cycle
    // ====================

    task automatic drive();
        logic [31:0] r;

        alloc_rdy <= (grants < NUM_MISSES) && roll(85);
        if (resv_q.size() > 0 && roll(70)) begin
            r = next_rand();
            update_en <= 1'b1;
            update_idx <= resv_q.pop_front();
            update_tag <= r[31:12];
            update_set <= r[11:4];
            update_way <= r[3:2];
            r = next_rand();
            update_txnid <= r[31:24];
        end else begin
            update_en <= 1'b0;
        end
        ds_req_rdy <= !(cycle >= DS_STALL_BEGIN && cycle < DS_STALL_END) && roll(75);
        lf_wr_rdy <= (cycle >= LF_STALL_END) && roll(75);
        // an offered slot holds until taken
        if (!(lfdb_alloc_vld && !lfdb_alloc_rdy)) begin
            r = next_rand();
            lfdb_alloc_vld <= roll(75);
            lfdb_alloc_id <= r[25:24];
        end
        if (data_idx_q.size() > 0 && roll(60)) begin
            ds_done <= 1'b1;
            ds_done_idx <= data_idx_q.pop_front();
            ds_done_lfdb_id <= data_lfdb_q.pop_front();
        end else begin
            ds_done <= 1'b0;
        end
        if (fill_q.size() > 0 && roll(60)) begin
            fill_done <= 1'b1;
            fill_done_idx <= fill_q.pop_front();
        end else begin
            fill_done <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            other_errs++;
            $display("ERROR run did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run();
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        alloc_rdy = 1'b0;
        update_en = 1'b0;
        update_idx = '0;
        update_tag = '0;
        update_set = '0;
        update_way = '0;
        update_txnid = '0;
        ds_req_rdy = 1'b0;
        lfdb_alloc_vld = 1'b0;
        lfdb_alloc_id = '0;
        ds_done = 1'b0;
        ds_done_idx = '0;
        ds_done_lfdb_id = '0;
        lf_wr_rdy = 1'b0;
        fill_done = 1'b0;
        fill_done_idx = '0;
        for (int i = 0; i < N; i++) begin
            st[i] = mshr_pkg::IDLE;
            ds_won[i] = '0;
            lf_won[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(posedge clk);
        check_eq("alloc_vld", 1, alloc_vld);
        check_eq("alloc_idx", 0, alloc_idx);
        check_eq("ds_req_vld", 0, ds_req_vld);
        check_eq("lf_wr_vld", 0, lf_wr_vld);
        check_eq("lfdb_alloc_rdy", 0, lfdb_alloc_rdy);
        observe();
        drive();
        while (!(grants == NUM_MISSES && done_misses == NUM_MISSES)) begin
            @(posedge clk);
            observe();
            drive();
        end

        check_eq("request_count", pulses, reqs);
        check_true(full_seen, "all entries were never busy at once");
        finish_run();
    end

endmodule

`default_nettype wire

// ==== hw/mshr_top.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module mshr_top (
    input  logic                   clk,
    input  logic                   rst,

    output logic                   alloc_vld,
    output mshr_pkg::entry_idx_t   alloc_idx,
    input  logic                   alloc_rdy,

    input  logic                   update_en,
    input  mshr_pkg::entry_idx_t   update_idx,
    input  cache_addr_pkg::tag_t   update_tag,
    input  cache_addr_pkg::set_t   update_set,
    input  cache_addr_pkg::way_t   update_way,
    input  mshr_pkg::txnid_t       update_txnid,

    output logic                   ds_req_vld,
    output mshr_pkg::entry_idx_t   ds_req_idx,
    output cache_addr_pkg::tag_t   ds_req_tag,
    output cache_addr_pkg::set_t   ds_req_set,
    output mshr_pkg::txnid_t       ds_req_txnid,
    output mshr_pkg::lfdb_id_t     ds_req_lfdb_id,
    input  logic                   ds_req_rdy,

    input  logic                   lfdb_alloc_vld,
    input  mshr_pkg::lfdb_id_t     lfdb_alloc_id,
    output logic                   lfdb_alloc_rdy,

    input  logic                   ds_done,
    input  mshr_pkg::entry_idx_t   ds_done_idx,
    input  mshr_pkg::lfdb_id_t     ds_done_lfdb_id,

    output logic                   lf_wr_vld,
    output mshr_pkg::entry_idx_t   lf_wr_idx,
    output cache_addr_pkg::set_t   lf_wr_set,
    output cache_addr_pkg::way_t   lf_wr_way,
    output mshr_pkg::lfdb_id_t     lf_wr_lfdb_id,
    input  logic                   lf_wr_rdy,

    input  logic                   fill_done,
    input  mshr_pkg::entry_idx_t   fill_done_idx
);

    localparam int DS_PLD_W = $bits(cache_addr_pkg::tag_t) + $bits(cache_addr_pkg::set_t)
                            + $bits(mshr_pkg::txnid_t);
    localparam int LF_PLD_W = $bits(cache_addr_pkg::set_t) + $bits(cache_addr_pkg::way_t)
                            + $bits(mshr_pkg::lfdb_id_t);

    logic [`MSHR_ENTRY_NUM-1:0] free;
    logic [`MSHR_ENTRY_NUM-1:0] take;
    logic [`MSHR_ENTRY_NUM-1:0] ds_vld;
    logic [`MSHR_ENTRY_NUM-1:0] ds_gnt;
    logic [`MSHR_ENTRY_NUM-1:0] lf_vld;
    logic [`MSHR_ENTRY_NUM-1:0] lf_gnt;
    logic [DS_PLD_W-1:0]        ds_pld [`MSHR_ENTRY_NUM-1:0];
    logic [LF_PLD_W-1:0]        lf_pld [`MSHR_ENTRY_NUM-1:0];

    logic                       arb_ds_vld;
    mshr_pkg::entry_idx_t       arb_ds_idx;
    logic [DS_PLD_W-1:0]        arb_ds_pld;
    logic                       arb_ds_rdy;
    cache_addr_pkg::tag_t       arb_ds_tag;
    cache_addr_pkg::set_t       arb_ds_set;
    mshr_pkg::txnid_t           arb_ds_txnid;
    logic [LF_PLD_W-1:0]        lf_wr_pld;

    // ====================
    // allocate
    // ====================

    mshr_alloc u_alloc (
        .free      (free),
        .alloc_rdy (alloc_rdy),
        .alloc_vld (alloc_vld),
        .alloc_idx (alloc_idx),
        .take      (take)
    );

    // ====================
    // entry array
    // ====================

    for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : g_entry
        cache_addr_pkg::tag_t e_tag;
        cache_addr_pkg::set_t e_ds_set;
        mshr_pkg::txnid_t     e_txnid;
        cache_addr_pkg::set_t e_lf_set;
        cache_addr_pkg::way_t e_way;
        mshr_pkg::lfdb_id_t   e_lfdb_id;

        mshr_entry #(
            .ENTRY_ID (i)
        ) u_entry (
            .clk             (clk),
            .rst             (rst),
            .take            (take[i]),
            .update_en       (update_en),
            .update_idx      (update_idx),
            .update_tag      (update_tag),
            .update_set      (update_set),
            .update_way      (update_way),
            .update_txnid    (update_txnid),
            .ds_gnt          (ds_gnt[i]),
            .ds_done         (ds_done),
            .ds_done_idx     (ds_done_idx),
            .ds_done_lfdb_id (ds_done_lfdb_id),
            .lf_gnt          (lf_gnt[i]),
            .fill_done       (fill_done),
            .fill_done_idx   (fill_done_idx),
            .free            (free[i]),
            .ds_vld          (ds_vld[i]),
            .ds_tag          (e_tag),
            .ds_set          (e_ds_set),
            .ds_txnid        (e_txnid),
            .lf_vld          (lf_vld[i]),
            .lf_set          (e_lf_set),
            .lf_way          (e_way),
            .lf_lfdb_id      (e_lfdb_id)
        );

        assign ds_pld[i] = {e_tag, e_ds_set, e_txnid};
        assign lf_pld[i] = {e_lf_set, e_way, e_lfdb_id};
    end

    // ====================
    // arbitrate and issue
    // ====================

    mshr_rr_arb #(
        .N     (`MSHR_ENTRY_NUM),
        .PLD_W (DS_PLD_W)
    ) u_ds_arb (
        .clk     (clk),
        .rst     (rst),
        .req     (ds_vld),
        .pld_in  (ds_pld),
        .gnt     (ds_gnt),
        .out_vld (arb_ds_vld),
        .out_idx (arb_ds_idx),
        .out_pld (arb_ds_pld),
        .out_rdy (arb_ds_rdy)
    );

    assign {arb_ds_tag, arb_ds_set, arb_ds_txnid} = arb_ds_pld;

    mshr_ds_issue u_ds_issue (
        .clk            (clk),
        .rst            (rst),
        .in_vld         (arb_ds_vld),
        .in_idx         (arb_ds_idx),
        .in_tag         (arb_ds_tag),
        .in_set         (arb_ds_set),
        .in_txnid       (arb_ds_txnid),
        .in_rdy         (arb_ds_rdy),
        .lfdb_alloc_vld (lfdb_alloc_vld),
        .lfdb_alloc_id  (lfdb_alloc_id),
        .lfdb_alloc_rdy (lfdb_alloc_rdy),
        .ds_req_vld     (ds_req_vld),
        .ds_req_idx     (ds_req_idx),
        .ds_req_tag     (ds_req_tag),
        .ds_req_set     (ds_req_set),
        .ds_req_txnid   (ds_req_txnid),
        .ds_req_lfdb_id (ds_req_lfdb_id),
        .ds_req_rdy     (ds_req_rdy)
    );

    // linefill write goes straight out to the data ram
    mshr_rr_arb #(
        .N     (`MSHR_ENTRY_NUM),
        .PLD_W (LF_PLD_W)
    ) u_lf_arb (
        .clk     (clk),
        .rst     (rst),
        .req     (lf_vld),
        .pld_in  (lf_pld),
        .gnt     (lf_gnt),
        .out_vld (lf_wr_vld),
        .out_idx (lf_wr_idx),
        .out_pld (lf_wr_pld),
        .out_rdy (lf_wr_rdy)
    );

    assign {lf_wr_set, lf_wr_way, lf_wr_lfdb_id} = lf_wr_pld;

endmodule

`default_nettype wire

// ==== hw/mshr_ds_issue.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module mshr_ds_issue (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_vld,
    input  mshr_pkg::entry_idx_t   in_idx,
    input  cache_addr_pkg::tag_t   in_tag,
    input  cache_addr_pkg::set_t   in_set,
    input  mshr_pkg::txnid_t       in_txnid,
    output logic                   in_rdy,

    input  logic                   lfdb_alloc_vld,
    input  mshr_pkg::lfdb_id_t     lfdb_alloc_id,
    output logic                   lfdb_alloc_rdy,

    output logic                   ds_req_vld,
    output mshr_pkg::entry_idx_t   ds_req_idx,
    output cache_addr_pkg::tag_t   ds_req_tag,
    output cache_addr_pkg::set_t   ds_req_set,
    output mshr_pkg::txnid_t       ds_req_txnid,
    output mshr_pkg::lfdb_id_t     ds_req_lfdb_id,
    input  logic                   ds_req_rdy
);

    logic load;

    // needs a free buffer slot and room in the register
    assign in_rdy = lfdb_alloc_vld & (~ds_req_vld | ds_req_rdy);
    assign load   = in_vld & in_rdy;

    // slot consumed together with the request
    assign lfdb_alloc_rdy = load;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_req_vld <= 1'b0;
        end else if (load) begin
            ds_req_vld <= 1'b1;
        end else if (ds_req_rdy) begin
            ds_req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ds_req_idx     <= in_idx;
            ds_req_tag     <= in_tag;
            ds_req_set     <= in_set;
            ds_req_txnid   <= in_txnid;
            ds_req_lfdb_id <= lfdb_alloc_id;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mshr_rr_arb.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module mshr_rr_arb #(
    parameter int N          = `MSHR_ENTRY_NUM,
    parameter int PLD_W      = 8,
    localparam int IDX_W     = (N > 1) ? $clog2(N) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [N-1:0]     req,
    input  logic [PLD_W-1:0] pld_in [N-1:0],
    output logic [N-1:0]     gnt,
    output logic             out_vld,
    output logic [IDX_W-1:0] out_idx,
    output logic [PLD_W-1:0] out_pld,
    input  logic             out_rdy
);

    logic [IDX_W-1:0] ptr_q;
    logic             hold_q;
    logic [IDX_W-1:0] hold_idx_q;
    logic             rr_found;
    logic [IDX_W-1:0] rr_idx;
    logic             xfer;

    // first requester at or after the pointer
    always_comb begin
        int cand;
        rr_found = 1'b0;
        rr_idx   = '0;
        for (int k = 0; k < N; k++) begin
            cand = (int'(ptr_q) + k) % N;
            if (!rr_found && req[cand]) begin
                rr_found = 1'b1;
                rr_idx   = IDX_W'(cand);
            end
        end
    end

    // a stalled winner stays selected so valid and payload hold
    assign out_vld = hold_q | rr_found;
    assign out_idx = hold_q ? hold_idx_q : rr_idx;
    assign out_pld = pld_in[out_idx];
    assign xfer    = out_vld & out_rdy;

    always_comb begin
        gnt = '0;
        if (xfer) begin
            gnt[out_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            hold_q     <= out_vld & ~out_rdy;
            hold_idx_q <= out_idx;
            if (xfer) begin
                ptr_q <= (out_idx == IDX_W'(N - 1)) ? '0 : out_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mshr_entry.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module mshr_entry #(
    parameter int ENTRY_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   take,

    input  logic                   update_en,
    input  mshr_pkg::entry_idx_t   update_idx,
    input  cache_addr_pkg::tag_t   update_tag,
    input  cache_addr_pkg::set_t   update_set,
    input  cache_addr_pkg::way_t   update_way,
    input  mshr_pkg::txnid_t       update_txnid,

    input  logic                   ds_gnt,
    input  logic                   ds_done,
    input  mshr_pkg::entry_idx_t   ds_done_idx,
    input  mshr_pkg::lfdb_id_t     ds_done_lfdb_id,

    input  logic                   lf_gnt,
    input  logic                   fill_done,
    input  mshr_pkg::entry_idx_t   fill_done_idx,

    output logic                   free,
    output logic                   ds_vld,
    output cache_addr_pkg::tag_t   ds_tag,
    output cache_addr_pkg::set_t   ds_set,
    output mshr_pkg::txnid_t       ds_txnid,
    output logic                   lf_vld,
    output cache_addr_pkg::set_t   lf_set,
    output cache_addr_pkg::way_t   lf_way,
    output mshr_pkg::lfdb_id_t     lf_lfdb_id
);

    localparam mshr_pkg::entry_idx_t MY_IDX = mshr_pkg::entry_idx_t'(ENTRY_ID);

    mshr_pkg::entry_state_t state_q;
    mshr_pkg::entry_state_t state_d;

    cache_addr_pkg::tag_t   tag_q;
    cache_addr_pkg::set_t   set_q;
    cache_addr_pkg::way_t   way_q;
    mshr_pkg::txnid_t       txnid_q;
    mshr_pkg::lfdb_id_t     lfdb_id_q;

    logic update_hit;
    logic done_hit;
    logic fill_hit;

    // ====================
    // broadcast decode
    // ====================

    assign update_hit = update_en & (update_idx == MY_IDX);
    assign done_hit   = ds_done & (ds_done_idx == MY_IDX);
    assign fill_hit   = fill_done & (fill_done_idx == MY_IDX);

    // ====================
    // state machine
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            mshr_pkg::IDLE: begin
                if (take) begin
                    state_d = mshr_pkg::RESERVED;
                end
            end
            mshr_pkg::RESERVED: begin
                if (update_hit) begin
                    state_d = mshr_pkg::DS_REQ;
                end
            end
            mshr_pkg::DS_REQ: begin
                // granted means the issue stage took it
                if (ds_gnt) begin
                    state_d = mshr_pkg::WAIT_DATA;
                end
            end
            mshr_pkg::WAIT_DATA: begin
                if (done_hit) begin
                    state_d = mshr_pkg::LF_WRITE;
                end
            end
            mshr_pkg::LF_WRITE: begin
                if (lf_gnt) begin
                    state_d = mshr_pkg::WAIT_FILL;
                end
            end
            mshr_pkg::WAIT_FILL: begin
                if (fill_hit) begin
                    state_d = mshr_pkg::IDLE;
                end
            end
            default: begin
                state_d = mshr_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mshr_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // miss fields from the tag pipe, buffer slot from the data return
    always_ff @(posedge clk) begin
        if (update_hit && state_q == mshr_pkg::RESERVED) begin
            tag_q   <= update_tag;
            set_q   <= update_set;
            way_q   <= update_way;
            txnid_q <= update_txnid;
        end
        if (done_hit && state_q == mshr_pkg::WAIT_DATA) begin
            lfdb_id_q <= ds_done_lfdb_id;
        end
    end

    // ====================
    // outputs
    // ====================

    assign free       = (state_q == mshr_pkg::IDLE);
    assign ds_vld     = (state_q == mshr_pkg::DS_REQ);
    assign ds_tag     = tag_q;
    assign ds_set     = set_q;
    assign ds_txnid   = txnid_q;
    assign lf_vld     = (state_q == mshr_pkg::LF_WRITE);
    assign lf_set     = set_q;
    assign lf_way     = way_q;
    assign lf_lfdb_id = lfdb_id_q;

endmodule

`default_nettype wire

// ==== hw/mshr_alloc.sv ====
`default_nettype none

`include "mshr_cfg.svh"

module mshr_alloc (
    input  logic [`MSHR_ENTRY_NUM-1:0] free,
    input  logic                       alloc_rdy,
    output logic                       alloc_vld,
    output mshr_pkg::entry_idx_t       alloc_idx,
    output logic [`MSHR_ENTRY_NUM-1:0] take
);

    logic grant;

    // lowest free entry wins, scan from the top down
    always_comb begin
        alloc_vld = 1'b0;
        alloc_idx = '0;
        for (int i = `MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (free[i]) begin
                alloc_vld = 1'b1;
                alloc_idx = mshr_pkg::entry_idx_t'(i);
            end
        end
    end

    assign grant = alloc_vld & alloc_rdy;

    // one-hot take back to the chosen entry
    always_comb begin
        take = '0;
        if (grant) begin
            take[alloc_idx] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mshr_pkg.sv ====
`default_nettype none

`include "mshr_cfg.svh"

package mshr_pkg;

    // ====================
    // index and id types
    // ====================

    typedef logic [$clog2(`MSHR_ENTRY_NUM)-1:0] entry_idx_t;

    // requester transaction id, returned with the fill
    typedef logic [`TXNID_W-1:0] txnid_t;

    // linefill buffer slot
    typedef logic [`LFDB_ID_W-1:0] lfdb_id_t;

    // ====================
    // entry life cycle
    // ====================

    // one miss, allocate through release
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        RESERVED  = 3'd1,
        DS_REQ    = 3'd2,
        WAIT_DATA = 3'd3,
        LF_WRITE  = 3'd4,
        WAIT_FILL = 3'd5
    } entry_state_t;

endpackage

`default_nettype wire

// ==== hw/cache_addr_pkg.sv ====
`default_nettype none

`include "mshr_cfg.svh"

package cache_addr_pkg;

    // address tag of a missed line
    typedef logic [`TAG_W-1:0] tag_t;

    // set index into tag and data ram
    typedef logic [`SET_W-1:0] set_t;

    // victim way picked by the tag pipe
    typedef logic [$clog2(`WAY_NUM)-1:0] way_t;

endpackage

`default_nettype wire

// ==== hw/mshr_cfg.svh ====
`ifndef MSHR_CFG_SVH
`define MSHR_CFG_SVH

// ====================
// mshr sizing
// ====================

// entries in the miss table
`define MSHR_ENTRY_NUM 8

// ====================
// cache address fields
// ====================

`define TAG_W 20
`define SET_W 8
`define WAY_NUM 4

// ====================
// id widths
// ====================

`define TXNID_W 8
// linefill buffer slot, one quarter of the lfdb
`define LFDB_ID_W 2

`endif
